// ==== all.f ====
+incdir+source
source/priv_pkg.sv
source/priv_trap_control.sv
source/priv_csr_port.sv
source/priv_csr_arbiter.sv
source/priv_csr_file.sv
source/priv_unit.sv
bench/priv_unit_tb.sv

// ==== bench/priv_unit_stimulus.txt ====
# name op f1 f2 f3 f4, all fields in hex.
# csr: op addr wdata old | rnd: op | exc: lines epc badaddr | irq: lines intr | clear: op addr wdata stalls
scr_write      rnd   1 0   0        0
scr_set        rnd   2 0   0        0
scr_clear      rnd   3 0   0        0
tvec_write     csr   1 305 80001003 00000000
tvec_read      csr   0 305 0        80001000
tvec_set       csr   2 305 00000f00 80001000
tvec_read_set  csr   0 305 0        80001f00
tvec_clear     csr   3 305 00001100 80001f00
tvec_read_clr  csr   0 305 0        80000e00
lf_raise       exc   7 1000 1004    0
lf_commit      clear 0 0   0        0
lf_cause       csr   0 342 0        00000005
lf_epc         csr   0 341 0        00001000
lf_bad         csr   0 343 0        00001004
bp_raise       exc   150 2000 deadbeef 0
bp_commit      clear 0 0   0        0
bp_cause       csr   0 342 0        00000003
bp_epc         csr   0 341 0        00002000
bp_bad         csr   0 343 0        00001004
ie_set         csr   2 300 8        0
ie_read        csr   0 300 0        8
ecall_raise    exc   20 3000 0      0
ecall_commit   clear 0 0   0        0
ie_entry       csr   0 300 0        0
mret_pulse     ret   0 0   0        0
ie_mret        csr   0 300 0        8
mie_soft       csr   1 304 8        0
timer_gated    irq   1 0   0        0
mip_gated      csr   0 344 0        80
cause_kept     csr   0 342 0        0000000b
timer_clear    irq   8 0   0        0
mie_timer      csr   1 304 80       8
timer_fire     irq   1 1   0        0
timer_commit   clear 0 0   0        0
timer_cause    csr   0 342 0        80000007
ie_timer       csr   0 300 0        0
timer_clear2   irq   8 0   0        0
stall_raise    exc   1 4000 4444    0
stall_commit   clear 1 305 00003000 4
stall_tvec     csr   0 305 0        00003000
stall_epc      csr   0 341 0        00004000
stall_cause    csr   0 342 0        00000005
stall_bad      csr   0 343 0        00004444

// ==== bench/priv_unit_tb.sv ====
`default_nettype none
`include "priv_settings.svh"

module priv_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CYCLES_PER_LINE = 40;  // Timeout budget per line.

  logic                CLK = 1'b0;
  logic                nRST;
  logic [8:0]          exc_lines;  // fault_l in bit 0 up to mal_insn in bit 8.
  logic                ret, pipe_clear;
  priv_pkg::word_t     epc, badaddr;
  logic                timer_int, soft_int, ext_int, clear_timer_int;
  priv_pkg::csr_op_t   csr_op;
  priv_pkg::csr_addr_t csr_addr;
  priv_pkg::word_t     csr_wdata;
  logic                intr, trap_done, csr_stall;
  priv_pkg::word_t     trap_vector, csr_rdata;

  // Parsed stimulus lines.
  string           names[$];
  string           ops[$];
  priv_pkg::word_t f1[$], f2[$], f3[$], f4[$];

  int              cycle_count   = 0;
  int              cycle_limit   = 0;  // Zero until the file is loaded.
  logic [31:0]     lfsr_state    = 32'd1691;
  priv_pkg::word_t scratch_model = '0;  // Expected mscratch.

  priv_unit u_dut (
    .CLK(CLK), .nRST(nRST),
    .fault_l(exc_lines[0]), .mal_l(exc_lines[1]), .fault_s(exc_lines[2]),
    .mal_s(exc_lines[3]), .breakpoint(exc_lines[4]), .env_m(exc_lines[5]),
    .illegal_insn(exc_lines[6]), .fault_insn(exc_lines[7]), .mal_insn(exc_lines[8]),
    .ret(ret), .pipe_clear(pipe_clear), .epc(epc), .badaddr(badaddr),
    .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
    .clear_timer_int(clear_timer_int),
    .csr_op(csr_op), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
    .intr(intr), .trap_done(trap_done), .trap_vector(trap_vector),
    .csr_rdata(csr_rdata), .csr_stall(csr_stall)
  );

  initial begin
    forever #50 CLK = ~CLK;  // 100 ns period.
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input priv_pkg::word_t expected,
                             input priv_pkg::word_t actual);
    if (expected !== actual) begin
      stop_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Watchdog on the whole run.
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      stop_run($sformatf("The run timed out after %0d clock cycles.", cycle_count));
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = state >> 1;
    if (state[0]) lfsr_next = lfsr_next ^ 32'h8020_0003;
  endfunction

  task automatic random_word(output priv_pkg::word_t word);
    word = '0;
    for (int i = 0; i < `PRIV_XLEN; i++) begin
      word       = {word[`PRIV_XLEN-2:0], lfsr_state[0]};  // One step per bit.
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic load_stimulus();
    int              fd;
    int              code;
    int              ch;
    string           tok, op;
    priv_pkg::word_t a, b, c, d;
    fd = $fopen("bench/priv_unit_stimulus.txt", "r");
    if (fd == 0) begin
      stop_run("Could not open the stimulus file bench/priv_unit_stimulus.txt.");
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          ch = $fgetc(fd);  // Skip the rest of a comment line.
          while (ch != "\n" && ch != -1) ch = $fgetc(fd);
        end else begin
          code = $fscanf(fd, "%s %h %h %h %h", op, a, b, c, d);
          if (code != 5) begin
            stop_run({"The stimulus line ", tok, " has missing fields."});
          end else begin
            names.push_back(tok);
            ops.push_back(op);
            f1.push_back(a);
            f2.push_back(b);
            f3.push_back(c);
            f4.push_back(d);
          end
        end
      end
      $fclose(fd);
      if (names.size() == 0) stop_run("The stimulus file holds no test lines.");
    end
  endtask

  // Software access held until the arbiter grants it.
  task automatic csr_access(input string name, input priv_pkg::csr_op_t op,
                            input priv_pkg::csr_addr_t addr, input priv_pkg::word_t data,
                            input priv_pkg::word_t old_value);
    @(posedge CLK);
    csr_op    <= op;
    csr_addr  <= addr;
    csr_wdata <= data;
    @(negedge CLK);
    while (csr_stall) @(negedge CLK);
    check_value(name, old_value, csr_rdata);  // Old value comes back.
    if (op == priv_pkg::CSR_OP_NONE && addr == `PRIV_ADDR_MTVEC)
      check_value({name, " vector"}, old_value, trap_vector);
    @(posedge CLK);
    csr_op <= priv_pkg::CSR_OP_NONE;  // Write lands on this edge.
  endtask

  // mscratch access with LFSR data, then a read back.
  task automatic random_access(input string name, input priv_pkg::csr_op_t op);
    priv_pkg::word_t data;
    random_word(data);
    csr_access(name, op, `PRIV_ADDR_MSCRATCH, data, scratch_model);
    case (op)
      priv_pkg::CSR_OP_WRITE: scratch_model = data;
      priv_pkg::CSR_OP_SET:   scratch_model = scratch_model | data;
      priv_pkg::CSR_OP_CLEAR: scratch_model = scratch_model & ~data;
      default: ;
    endcase
    csr_access({name, " read"}, priv_pkg::CSR_OP_NONE, `PRIV_ADDR_MSCRATCH, '0,
               scratch_model);
  endtask

  task automatic raise_exceptions(input string name, input logic [8:0] lines,
                                  input priv_pkg::word_t pc, input priv_pkg::word_t addr);
    @(posedge CLK);
    exc_lines <= lines;  // Held until the commit.
    epc       <= pc;
    badaddr   <= addr;
    @(negedge CLK);
    check_value({name, " intr"}, 1, intr);
  endtask

  task automatic pulse_interrupts(input string name, input logic [3:0] lines,
                                  input logic expect_intr);
    @(posedge CLK);
    timer_int       <= lines[0];
    soft_int        <= lines[1];
    ext_int         <= lines[2];
    clear_timer_int <= lines[3];
    @(posedge CLK);
    {timer_int, soft_int, ext_int, clear_timer_int} <= 4'b0;
    if (expect_intr) begin
      @(negedge CLK);
      while (!intr) @(negedge CLK);  // Watchdog covers a missing interrupt.
    end else begin
      repeat (4) begin
        @(negedge CLK);
        check_value({name, " intr"}, 0, intr);
      end
    end
  endtask

  // pipe_clear pulse with an optional racing software write.
  task automatic commit_trap(input string name, input priv_pkg::csr_op_t op,
                             input priv_pkg::csr_addr_t addr, input priv_pkg::word_t data,
                             input priv_pkg::word_t stalls_expected);
    int cycles;
    int done_cycle;
    int stalls;
    @(posedge CLK);
    pipe_clear <= 1'b1;
    @(posedge CLK);
    pipe_clear <= 1'b0;
    exc_lines  <= '0;
    csr_op     <= op;
    csr_addr   <= addr;
    csr_wdata  <= data;
    cycles     = 1;
    done_cycle = 0;
    stalls     = 0;
    @(negedge CLK);
    while (done_cycle == 0 || csr_stall) begin
      if (csr_stall) stalls++;
      if (trap_done) done_cycle = cycles;
      cycles++;
      @(negedge CLK);
    end
    check_value({name, " commit length"}, 4, done_cycle);
    check_value({name, " stall cycles"}, stalls_expected, stalls);
    check_value({name, " intr"}, 0, intr);
    @(posedge CLK);
    csr_op <= priv_pkg::CSR_OP_NONE;
  endtask

  task automatic return_from_trap(input string name);
    int cycles;
    @(posedge CLK);
    ret <= 1'b1;
    @(posedge CLK);
    ret    <= 1'b0;
    cycles = 1;
    @(negedge CLK);
    while (!trap_done) begin
      cycles++;
      @(negedge CLK);
    end
    check_value({name, " mret length"}, 1, cycles);  // Single status step.
  endtask

  initial begin
    nRST            = 1'b0;
    exc_lines       = '0;
    ret             = 1'b0;
    pipe_clear      = 1'b0;
    epc             = '0;
    badaddr         = '0;
    timer_int       = 1'b0;
    soft_int        = 1'b0;
    ext_int         = 1'b0;
    clear_timer_int = 1'b0;
    csr_op          = priv_pkg::CSR_OP_NONE;
    csr_addr        = '0;
    csr_wdata       = '0;
    load_stimulus();
    cycle_limit = CYCLES_PER_LINE * names.size();
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    foreach (names[i]) begin
      if (ops[i] == "csr")
        csr_access(names[i], f1[i][1:0], f2[i][11:0], f3[i], f4[i]);
      else if (ops[i] == "rnd")
        random_access(names[i], f1[i][1:0]);
      else if (ops[i] == "exc")
        raise_exceptions(names[i], f1[i][8:0], f2[i], f3[i]);
      else if (ops[i] == "irq")
        pulse_interrupts(names[i], f1[i][3:0], f2[i][0]);
      else if (ops[i] == "clear")
        commit_trap(names[i], f1[i][1:0], f2[i][11:0], f3[i], f4[i]);
      else if (ops[i] == "ret")
        return_from_trap(names[i]);
      else
        stop_run({"Line ", names[i], " has an unknown operation ", ops[i], "."});
    end
    repeat (2) @(posedge CLK);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/priv_unit.sv ====
`default_nettype none
`include "priv_settings.svh"

module priv_unit (
  input  wire logic                 CLK,
  input  wire logic                 nRST,
  input  wire logic                 fault_l,
  input  wire logic                 mal_l,
  input  wire logic                 fault_s,
  input  wire logic                 mal_s,
  input  wire logic                 breakpoint,
  input  wire logic                 env_m,
  input  wire logic                 illegal_insn,
  input  wire logic                 fault_insn,
  input  wire logic                 mal_insn,
  input  wire logic                 ret,
  input  wire logic                 pipe_clear,
  input  wire priv_pkg::word_t      epc,
  input  wire priv_pkg::word_t      badaddr,
  input  wire logic                 timer_int,
  input  wire logic                 soft_int,
  input  wire logic                 ext_int,
  input  wire logic                 clear_timer_int,
  input  wire priv_pkg::csr_op_t    csr_op,
  input  wire priv_pkg::csr_addr_t  csr_addr,
  input  wire priv_pkg::word_t      csr_wdata,
  output logic                      intr,
  output logic                      trap_done,
  output priv_pkg::word_t           trap_vector,
  output priv_pkg::word_t           csr_rdata,
  output logic                      csr_stall
);

  // Trap controller requests.
  logic                trap_wr_req;
  priv_pkg::csr_addr_t trap_wr_addr;
  priv_pkg::word_t     trap_wr_data;
  // Software port requests.
  logic                sw_wr_req, sw_grant;
  priv_pkg::csr_addr_t sw_wr_addr;
  priv_pkg::word_t     sw_wr_data;
  // Shared write bus.
  logic                wr_en;
  priv_pkg::csr_addr_t wr_addr;
  priv_pkg::word_t     wr_data;
  // CSR file state.
  priv_pkg::csr_addr_t rd_addr;
  priv_pkg::word_t     rd_data, mie, mip;
  logic                mstatus_ie;

  priv_trap_control u_trap (
    .CLK(CLK), .nRST(nRST),
    .fault_l(fault_l), .mal_l(mal_l), .fault_s(fault_s), .mal_s(mal_s),
    .breakpoint(breakpoint), .env_m(env_m), .illegal_insn(illegal_insn),
    .fault_insn(fault_insn), .mal_insn(mal_insn),
    .ret(ret), .pipe_clear(pipe_clear), .epc(epc), .badaddr(badaddr),
    .mstatus_ie(mstatus_ie), .mie(mie), .mip(mip),
    .intr(intr), .trap_done(trap_done),
    .trap_wr_req(trap_wr_req), .trap_wr_addr(trap_wr_addr), .trap_wr_data(trap_wr_data)
  );

  priv_csr_port u_port (
    .csr_op(csr_op), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
    .rd_data(rd_data), .sw_grant(sw_grant),
    .rd_addr(rd_addr), .csr_rdata(csr_rdata), .csr_stall(csr_stall),
    .sw_wr_req(sw_wr_req), .sw_wr_addr(sw_wr_addr), .sw_wr_data(sw_wr_data)
  );

  priv_csr_arbiter u_arb (
    .trap_wr_req(trap_wr_req), .trap_wr_addr(trap_wr_addr), .trap_wr_data(trap_wr_data),
    .sw_wr_req(sw_wr_req), .sw_wr_addr(sw_wr_addr), .sw_wr_data(sw_wr_data),
    .sw_grant(sw_grant), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  // mtvec leaves here as the trap vector.
  priv_csr_file u_csrs (
    .CLK(CLK), .nRST(nRST),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_addr(rd_addr),
    .timer_int(timer_int), .soft_int(soft_int), .ext_int(ext_int),
    .clear_timer_int(clear_timer_int),
    .rd_data(rd_data), .mstatus_ie(mstatus_ie), .mie(mie), .mip(mip),
    .mtvec(trap_vector)
  );

endmodule

`default_nettype wire

// ==== source/priv_csr_file.sv ====
`default_nettype none
`include "priv_settings.svh"

module priv_csr_file (
  input  wire logic                 CLK,
  input  wire logic                 nRST,
  input  wire logic                 wr_en,
  input  wire priv_pkg::csr_addr_t  wr_addr,
  input  wire priv_pkg::word_t      wr_data,
  input  wire priv_pkg::csr_addr_t  rd_addr,
  input  wire logic                 timer_int,
  input  wire logic                 soft_int,
  input  wire logic                 ext_int,
  input  wire logic                 clear_timer_int,
  output priv_pkg::word_t           rd_data,
  output logic                      mstatus_ie,
  output priv_pkg::word_t           mie,
  output priv_pkg::word_t           mip,
  output priv_pkg::word_t           mtvec
);

  // Writable bits per register.
  localparam priv_pkg::word_t MSTATUS_MASK =
    priv_pkg::word_t'(1) << priv_pkg::MSTATUS_IE_BIT;
  localparam priv_pkg::word_t MIE_MASK =
    (priv_pkg::word_t'(1) << priv_pkg::MIE_MSIE_BIT) |
    (priv_pkg::word_t'(1) << priv_pkg::MIE_MTIE_BIT);
  localparam priv_pkg::word_t MTVEC_MASK = ~priv_pkg::word_t'(3);  // Direct mode, word aligned.
  localparam priv_pkg::word_t MCAUSE_MASK =
    (priv_pkg::word_t'(1) << (`PRIV_XLEN - 1)) |
    priv_pkg::word_t'((1 << `PRIV_CAUSE_W) - 1);

  priv_pkg::word_t mstatus;
  priv_pkg::word_t mscratch;
  priv_pkg::word_t mepc;
  priv_pkg::word_t mcause;
  priv_pkg::word_t mbadaddr;
  priv_pkg::word_t mip_next;  // Hardware pending-bit update.

  // Pending bits follow the interrupt lines, not the bus.
  always_comb begin
    mip_next = mip;
    if (timer_int)          mip_next[priv_pkg::MIE_MTIE_BIT] = 1'b1;
    if (soft_int || ext_int) mip_next[priv_pkg::MIE_MSIE_BIT] = 1'b1;
    if (clear_timer_int)    mip_next[priv_pkg::MIE_MTIE_BIT] = 1'b0;  // Clear wins.
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus  <= '0;
      mie      <= '0;
      mip      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mbadaddr <= '0;
    end else begin
      if (wr_en) begin
        case (wr_addr)
          `PRIV_ADDR_MSTATUS:  mstatus  <= wr_data & MSTATUS_MASK;
          `PRIV_ADDR_MIE:      mie      <= wr_data & MIE_MASK;
          `PRIV_ADDR_MTVEC:    mtvec    <= wr_data & MTVEC_MASK;
          `PRIV_ADDR_MSCRATCH: mscratch <= wr_data;
          `PRIV_ADDR_MEPC:     mepc     <= wr_data;
          `PRIV_ADDR_MCAUSE:   mcause   <= wr_data & MCAUSE_MASK;
          `PRIV_ADDR_MBADADDR: mbadaddr <= wr_data;
          default: ;  // mip and unknown numbers drop the write.
        endcase
      end
      mip <= mip_next;
    end
  end

  // Combinational read for the software port.
  always_comb begin
    case (rd_addr)
      `PRIV_ADDR_MSTATUS:  rd_data = mstatus;
      `PRIV_ADDR_MIE:      rd_data = mie;
      `PRIV_ADDR_MIP:      rd_data = mip;
      `PRIV_ADDR_MTVEC:    rd_data = mtvec;
      `PRIV_ADDR_MSCRATCH: rd_data = mscratch;
      `PRIV_ADDR_MEPC:     rd_data = mepc;
      `PRIV_ADDR_MCAUSE:   rd_data = mcause;
      `PRIV_ADDR_MBADADDR: rd_data = mbadaddr;
      default:             rd_data = '0;
    endcase
  end

  assign mstatus_ie = mstatus[priv_pkg::MSTATUS_IE_BIT];

endmodule

`default_nettype wire

// ==== source/priv_csr_arbiter.sv ====
`default_nettype none
`include "priv_settings.svh"

module priv_csr_arbiter (
  input  wire logic                 trap_wr_req,
  input  wire priv_pkg::csr_addr_t  trap_wr_addr,
  input  wire priv_pkg::word_t      trap_wr_data,
  input  wire logic                 sw_wr_req,
  input  wire priv_pkg::csr_addr_t  sw_wr_addr,
  input  wire priv_pkg::word_t      sw_wr_data,
  output logic                      sw_grant,
  output logic                      wr_en,
  output priv_pkg::csr_addr_t       wr_addr,
  output priv_pkg::word_t           wr_data
);

  // Trap commit has fixed priority over software.
  assign sw_grant = sw_wr_req & ~trap_wr_req;

  // One write per cycle on the shared bus.
  assign wr_en = trap_wr_req | sw_wr_req;

  // Winner's address and data onto the bus.
  always_comb begin
    if (trap_wr_req) begin
      wr_addr = trap_wr_addr;
      wr_data = trap_wr_data;
    end else begin
      wr_addr = sw_wr_addr;   // Ignored unless sw_wr_req.
      wr_data = sw_wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/priv_csr_port.sv ====
`default_nettype none
`include "priv_settings.svh"

module priv_csr_port (
  input  wire priv_pkg::csr_op_t    csr_op,
  input  wire priv_pkg::csr_addr_t  csr_addr,
  input  wire priv_pkg::word_t      csr_wdata,
  input  wire priv_pkg::word_t      rd_data,
  input  wire logic                 sw_grant,
  output priv_pkg::csr_addr_t       rd_addr,
  output priv_pkg::word_t           csr_rdata,
  output logic                      csr_stall,
  output logic                      sw_wr_req,
  output priv_pkg::csr_addr_t       sw_wr_addr,
  output priv_pkg::word_t           sw_wr_data
);

  priv_pkg::word_t new_value;  // Result of the read-modify-write.
  logic            has_bits;   // Nonzero mask for set and clear.

  // Read side is a straight lookup into the CSR file.
  assign rd_addr   = csr_addr;
  assign csr_rdata = rd_data;  // Old value back to the pipeline.

  assign has_bits = |csr_wdata;

  // New value formed from the current one.
  always_comb begin
    case (csr_op)
      priv_pkg::CSR_OP_WRITE: new_value = csr_wdata;
      priv_pkg::CSR_OP_SET:   new_value = rd_data | csr_wdata;
      priv_pkg::CSR_OP_CLEAR: new_value = rd_data & ~csr_wdata;
      default:                new_value = rd_data;
    endcase
  end

  // csrrs and csrrc with a zero mask only read.
  always_comb begin
    sw_wr_req = 1'b0;
    if (csr_op == priv_pkg::CSR_OP_WRITE) begin
      sw_wr_req = 1'b1;
    end else if (csr_op != priv_pkg::CSR_OP_NONE) begin
      sw_wr_req = has_bits;
    end
  end

  assign sw_wr_addr = csr_addr;
  assign sw_wr_data = new_value;

  // Pipeline holds the op steady until the bus is ours.
  assign csr_stall = sw_wr_req & ~sw_grant;

endmodule

`default_nettype wire

// ==== source/priv_trap_control.sv ====
`default_nettype none
`include "priv_settings.svh"

module priv_trap_control (
  input  wire logic             CLK,
  input  wire logic             nRST,
  input  wire logic             fault_l,
  input  wire logic             mal_l,
  input  wire logic             fault_s,
  input  wire logic             mal_s,
  input  wire logic             breakpoint,
  input  wire logic             env_m,
  input  wire logic             illegal_insn,
  input  wire logic             fault_insn,
  input  wire logic             mal_insn,
  input  wire logic             ret,
  input  wire logic             pipe_clear,
  input  wire priv_pkg::word_t  epc,
  input  wire priv_pkg::word_t  badaddr,
  input  wire logic             mstatus_ie,
  input  wire priv_pkg::word_t  mie,
  input  wire priv_pkg::word_t  mip,
  output logic                  intr,
  output logic                  trap_done,
  output logic                  trap_wr_req,
  output priv_pkg::csr_addr_t   trap_wr_addr,
  output priv_pkg::word_t       trap_wr_data
);

  priv_pkg::cause_t      ex_src;      // Winning exception code.
  logic                  exception;
  priv_pkg::cause_t      intr_src;    // Winning interrupt code.
  logic                  intr_fired;  // Enabled and pending.
  logic                  intr_latch;
  logic                  bad_cause;   // Cause reports an address.
  logic                  trap_start;
  priv_pkg::trap_state_t state, state_next;
  priv_pkg::word_t       epc_q, bad_q;
  priv_pkg::cause_t      cause_q;
  logic                  intr_q, bad_ok_q, ret_q;
  priv_pkg::word_t       cause_wd, status_wd;

  // Fixed exception priority with loads first.
  always_comb begin
    exception = 1'b1;
    ex_src    = priv_pkg::INSN_MAL;
    if (fault_l)           ex_src = priv_pkg::L_FAULT;
    else if (mal_l)        ex_src = priv_pkg::L_ADDR_MAL;
    else if (fault_s)      ex_src = priv_pkg::S_FAULT;
    else if (mal_s)        ex_src = priv_pkg::S_ADDR_MAL;
    else if (breakpoint)   ex_src = priv_pkg::BREAKPOINT;
    else if (env_m)        ex_src = priv_pkg::ENV_CALL_M;
    else if (illegal_insn) ex_src = priv_pkg::ILLEGAL_INSN;
    else if (fault_insn)   ex_src = priv_pkg::INSN_FAULT;
    else if (mal_insn)     ex_src = priv_pkg::INSN_MAL;
    else                   exception = 1'b0;
  end

  // Timer beats soft. External requests land in MSIP, so EXT_INT is the fallback.
  always_comb begin
    intr_src = priv_pkg::EXT_INT;
    if (mie[priv_pkg::MIE_MTIE_BIT] && mip[priv_pkg::MIE_MTIE_BIT])
      intr_src = priv_pkg::TIMER_INT;
    else if (mie[priv_pkg::MIE_MSIE_BIT] && mip[priv_pkg::MIE_MSIE_BIT])
      intr_src = priv_pkg::SOFT_INT;
  end

  assign intr_fired = mstatus_ie &
                      ((mie[priv_pkg::MIE_MTIE_BIT] & mip[priv_pkg::MIE_MTIE_BIT]) |
                       (mie[priv_pkg::MIE_MSIE_BIT] & mip[priv_pkg::MIE_MSIE_BIT]));

  assign intr       = exception | intr_latch;  // To pipeline control.
  assign bad_cause  = exception &&
                      !(ex_src inside {priv_pkg::BREAKPOINT, priv_pkg::ENV_CALL_M});
  assign trap_start = (state == priv_pkg::TRAP_IDLE) && pipe_clear &&
                      (exception || intr_latch);

  // Hold the interrupt until the pipe drains.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      intr_latch <= 1'b0;
    end else if (pipe_clear) begin
      intr_latch <= 1'b0;
    end else if (intr_fired && state == priv_pkg::TRAP_IDLE) begin  // ie stays set mid-commit.
      intr_latch <= 1'b1;
    end
  end

  // Trap context sampled on the pipe_clear cycle.
  always_ff @(posedge CLK) begin
    if (trap_start) begin
      epc_q    <= epc;
      bad_q    <= badaddr;
      cause_q  <= exception ? ex_src : intr_src;  // Exceptions beat interrupts.
      intr_q   <= ~exception;
      bad_ok_q <= bad_cause;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      priv_pkg::TRAP_IDLE: begin
        if (trap_start) state_next = priv_pkg::TRAP_EPC;
        else if (ret)   state_next = priv_pkg::TRAP_STATUS;  // mret takes one step.
      end
      priv_pkg::TRAP_EPC:   state_next = priv_pkg::TRAP_CAUSE;
      priv_pkg::TRAP_CAUSE: state_next = priv_pkg::TRAP_BAD;
      priv_pkg::TRAP_BAD:   state_next = priv_pkg::TRAP_STATUS;
      default:              state_next = priv_pkg::TRAP_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= priv_pkg::TRAP_IDLE;
      ret_q <= 1'b0;
    end else begin
      state <= state_next;
      if (state == priv_pkg::TRAP_IDLE) ret_q <= ret && !trap_start;
    end
  end

  // Write values for the mcause and mstatus steps.
  always_comb begin
    cause_wd                          = '0;
    cause_wd[`PRIV_XLEN-1]            = intr_q;
    cause_wd[`PRIV_CAUSE_W-1:0]       = cause_q;
    status_wd                         = '0;
    status_wd[priv_pkg::MSTATUS_IE_BIT] = ret_q;  // Set on mret, clear on entry.
  end

  always_comb begin
    trap_wr_req  = 1'b0;
    trap_wr_addr = `PRIV_ADDR_MEPC;
    trap_wr_data = epc_q;
    trap_done    = 1'b0;
    case (state)
      priv_pkg::TRAP_EPC: trap_wr_req = 1'b1;
      priv_pkg::TRAP_CAUSE: begin
        trap_wr_req  = 1'b1;
        trap_wr_addr = `PRIV_ADDR_MCAUSE;
        trap_wr_data = cause_wd;
      end
      priv_pkg::TRAP_BAD: begin
        trap_wr_req  = bad_ok_q;  // Skipped for breakpoint, ecall and interrupts.
        trap_wr_addr = `PRIV_ADDR_MBADADDR;
        trap_wr_data = bad_q;
      end
      priv_pkg::TRAP_STATUS: begin
        trap_wr_req  = 1'b1;
        trap_wr_addr = `PRIV_ADDR_MSTATUS;
        trap_wr_data = status_wd;
        trap_done    = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== source/priv_pkg.sv ====
`default_nettype none
`include "priv_settings.svh"

package priv_pkg;

  // Plain vectors for the widths that carry meaning.
  typedef logic [`PRIV_XLEN-1:0]    word_t;
  typedef logic [`PRIV_CSR_AW-1:0]  csr_addr_t;
  typedef logic [`PRIV_CAUSE_W-1:0] cause_t;
  typedef logic [1:0]               csr_op_t;

  // Software CSR operation encodings.
  localparam csr_op_t CSR_OP_NONE  = 2'b00;
  localparam csr_op_t CSR_OP_WRITE = 2'b01;  // csrrw.
  localparam csr_op_t CSR_OP_SET   = 2'b10;  // csrrs.
  localparam csr_op_t CSR_OP_CLEAR = 2'b11;  // csrrc.

  // Synchronous exception codes.
  localparam cause_t INSN_MAL     = cause_t'(0);
  localparam cause_t INSN_FAULT   = cause_t'(1);
  localparam cause_t ILLEGAL_INSN = cause_t'(2);
  localparam cause_t BREAKPOINT   = cause_t'(3);
  localparam cause_t L_ADDR_MAL   = cause_t'(4);
  localparam cause_t L_FAULT      = cause_t'(5);
  localparam cause_t S_ADDR_MAL   = cause_t'(6);
  localparam cause_t S_FAULT      = cause_t'(7);
  localparam cause_t ENV_CALL_M   = cause_t'(11);

  // Interrupt codes reported with mcause[31] set.
  localparam cause_t SOFT_INT  = cause_t'(3);
  localparam cause_t TIMER_INT = cause_t'(7);
  localparam cause_t EXT_INT   = cause_t'(11);

  // Bit positions in mstatus and mie.
  localparam int MSTATUS_IE_BIT = 3;
  localparam int MIE_MSIE_BIT   = 3;  // Same slot as mip.MSIP.
  localparam int MIE_MTIE_BIT   = 7;  // Same slot as mip.MTIP.

  // Trap commit sequencer with one CSR write per step.
  typedef enum logic [2:0] {
    TRAP_IDLE,
    TRAP_EPC,
    TRAP_CAUSE,
    TRAP_BAD,
    TRAP_STATUS
  } trap_state_t;

endpackage

`default_nettype wire

// ==== source/priv_settings.svh ====
`ifndef PRIV_SETTINGS_SVH
`define PRIV_SETTINGS_SVH

// Datapath widths.
`define PRIV_XLEN     32  // One machine word.
`define PRIV_CSR_AW   12  // CSR number field of the instruction.
`define PRIV_CAUSE_W  4   // Low code bits of mcause.

// Machine-mode CSR numbers.
`define PRIV_ADDR_MSTATUS   12'h300
`define PRIV_ADDR_MIE       12'h304
`define PRIV_ADDR_MTVEC     12'h305
`define PRIV_ADDR_MSCRATCH  12'h340
`define PRIV_ADDR_MEPC      12'h341
`define PRIV_ADDR_MCAUSE    12'h342
`define PRIV_ADDR_MBADADDR  12'h343
`define PRIV_ADDR_MIP       12'h344  // Read-only from software.

`endif
